//--- src/fhp_config.svh
//////////////////////////////////////////////////
// Frame header parser configuration
// Widths, format magic values and field positions
//////////////////////////////////////////////////
`ifndef FHP_CONFIG_SVH
`define FHP_CONFIG_SVH

`define FHP_DATA_W        64
`define FHP_STRB_W        8
`define FHP_CRC_W         32
`define FHP_FRM_BYTES_W   28
`define FHP_PFX_LEN_W     8

// Magic values of the first payload word
`define FHP_XP9_ID        32'h39505846
`define FHP_XP10_ID       32'h30315058
`define FHP_GZIP_ID1      8'h1f
`define FHP_GZIP_ID2      8'h8b
`define FHP_ZLIB_CM       4'h8

// XP10 prefix window and data header bits
`define FHP_XP10_PFX_LSB  36
`define FHP_XP10_PFX_MSB  43
`define FHP_LOC_BIT       0

`endif

//--- src/tlv_pkg.sv
//////////////////////////////////////////////////
// Input side types of the frame header parser
// TLV type codes and the TLV kind in progress
//////////////////////////////////////////////////
package tlv_pkg;

   // Type codes seen on the TLV stream
   typedef enum logic [4:0] {
      CMD      = 5'h01,
      DATA     = 5'h04,
      DATA_UNK = 5'h05,
      PFD      = 5'h07
   } tlv_type_e;

   // Kind of TLV currently flowing through the parser
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_PFX  = 2'd1,
      ST_DATA = 2'd2,
      ST_SKIP = 2'd3
   } fhp_state_e;

endpackage

//--- src/fhp_pkg.sv
//////////////////////////////////////////////////
// Output side types of the frame header parser
//////////////////////////////////////////////////
package fhp_pkg;

   typedef enum logic [2:0] {
      NONE = 3'd0,
      XP9  = 3'd1,
      XP10 = 3'd2,
      GZIP = 3'd3,
      ZLIB = 3'd4
   } frame_fmt_e;

   // Start-of-frame error codes
   typedef enum logic [3:0] {
      NO_ERRORS       = 4'd0,
      PFX_CRC         = 4'd1,
      PFX_DATA_ABSENT = 4'd2,
      BAD_FORMAT      = 4'd3
   } fhp_error_e;

endpackage

//--- src/crc32_64.sv
//////////////////////////////////////////////////
// CRC-32 step over one 64-bit word
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fhp_config.svh"

module crc32_64 (
   input  logic [`FHP_CRC_W-1:0]  crc_in,
   input  logic [`FHP_DATA_W-1:0] data_in,
   output logic [`FHP_CRC_W-1:0]  crc_out
);

   // Reflected form of 0x04C11DB7
   localparam logic [`FHP_CRC_W-1:0] crc_poly = 32'hEDB88320;

   // Bit serial, LSB of byte 0 first
   always_comb begin
      logic [`FHP_CRC_W-1:0] c;
      c = crc_in;
      for (int i = 0; i < `FHP_DATA_W; i++) begin
         if (c[0] ^ data_in[i]) begin
            c = (c >> 1) ^ crc_poly;
         end else begin
            c = c >> 1;
         end
      end
      crc_out = c;
   end

endmodule

//--- src/tlv_dispatch.sv
//////////////////////////////////////////////////
// TLV dispatch
// Registers the input beat and tracks the TLV kind
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fhp_config.svh"

module tlv_dispatch (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_valid,
   input  logic                     in_sot,
   input  logic                     in_eot,
   input  tlv_pkg::tlv_type_e       in_type,
   input  logic [`FHP_DATA_W-1:0]   in_data,
   input  logic [`FHP_STRB_W-1:0]   in_strb,
   output logic                     beat_valid,
   output logic                     beat_sot,
   output logic                     beat_eot,
   output logic [`FHP_DATA_W-1:0]   beat_data,
   output logic [`FHP_STRB_W-1:0]   beat_strb,
   output tlv_pkg::fhp_state_e      state
);
   import tlv_pkg::*;

   function automatic fhp_state_e kind_of(input tlv_type_e t);
      case (t)
         DATA, DATA_UNK: kind_of = ST_DATA;
         PFD:            kind_of = ST_PFX;
         default:        kind_of = ST_SKIP;
      endcase
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_valid <= 1'b0;
         beat_sot   <= 1'b0;
         beat_eot   <= 1'b0;
         state      <= ST_IDLE;
      end else begin
         beat_valid <= in_valid;
         beat_sot   <= in_valid && in_sot;
         beat_eot   <= in_valid && in_eot;
         // State lines up with the registered beat
         if (in_valid && in_sot) begin
            state <= kind_of(in_type);
         end else if (beat_valid && beat_eot) begin
            state <= ST_IDLE;
         end
      end
   end

   // Beat payload
   always_ff @(posedge clk) begin
      beat_data <= in_data;
      beat_strb <= in_strb;
   end

endmodule

//--- src/prefix_checker.sv
//////////////////////////////////////////////////
// Prefix checker
// Forwards prefix words and checks their CRC
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fhp_config.svh"

module prefix_checker (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        beat_valid,
   input  logic                        beat_sot,
   input  logic                        beat_eot,
   input  logic [`FHP_DATA_W-1:0]      beat_data,
   input  tlv_pkg::fhp_state_e         state,
   input  logic                        sof_valid,
   output logic                        pfx_valid,
   output logic [`FHP_DATA_W-1:0]      pfx_data,
   output logic                        pfx_sof,
   output logic                        pfx_last,
   output logic                        pfx_present,
   output logic [`FHP_PFX_LEN_W-1:0]   pfx_words,
   output logic                        pfx_crc_err
);
   import tlv_pkg::*;

   logic [`FHP_PFX_LEN_W-1:0] word_cnt;
   logic [`FHP_CRC_W-1:0]     crc_reg;
   logic [`FHP_CRC_W-1:0]     crc_next;
   logic                      pfx_hdr;
   logic                      pfx_word;
   logic                      pfx_trl;

   assign pfx_hdr  = beat_valid && (state == ST_PFX) && beat_sot;
   assign pfx_word = beat_valid && (state == ST_PFX) && !beat_sot && !beat_eot;
   assign pfx_trl  = beat_valid && (state == ST_PFX) && !beat_sot && beat_eot;

   crc32_64 u_crc (
      .crc_in  (crc_reg),
      .data_in (beat_data),
      .crc_out (crc_next)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pfx_valid   <= 1'b0;
         pfx_sof     <= 1'b0;
         pfx_last    <= 1'b0;
         pfx_present <= 1'b0;
         pfx_words   <= '0;
         pfx_crc_err <= 1'b0;
         word_cnt    <= '0;
         crc_reg     <= '1;
      end else begin
         pfx_valid <= pfx_word;
         pfx_sof   <= pfx_word && (word_cnt == '0);
         pfx_last  <= pfx_word && (word_cnt == pfx_words - 1'b1);

         if (pfx_hdr) begin
            word_cnt <= '0;
            crc_reg  <= '1;
         end else if (pfx_word) begin
            word_cnt <= word_cnt + 1'b1;
            crc_reg  <= crc_next;
         end

         // Flags stay up until the descriptor has gone out
         if (sof_valid) begin
            pfx_present <= 1'b0;
            pfx_words   <= '0;
            pfx_crc_err <= 1'b0;
         end else begin
            if (pfx_hdr) begin
               pfx_present <= 1'b1;
               pfx_words   <= beat_data[`FHP_PFX_LEN_W-1:0];
            end
            if (pfx_trl) begin
               pfx_crc_err <= (beat_data[`FHP_CRC_W-1:0] != ~crc_reg);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pfx_word) begin
         pfx_data <= beat_data;
      end
   end

endmodule

//--- src/data_framer.sv
//////////////////////////////////////////////////
// Data framer
// Forwards payload with frame flags, counts bytes
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fhp_config.svh"

module data_framer (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             beat_valid,
   input  logic                             beat_sot,
   input  logic                             beat_eot,
   input  logic [`FHP_DATA_W-1:0]           beat_data,
   input  logic [`FHP_STRB_W-1:0]           beat_strb,
   input  tlv_pkg::fhp_state_e              state,
   output logic                             dp_valid,
   output logic [`FHP_DATA_W-1:0]           dp_data,
   output logic                             dp_sof,
   output logic                             dp_eof,
   output logic [$clog2(`FHP_STRB_W)-1:0]   dp_bytes_valid,
   output logic [`FHP_FRM_BYTES_W-1:0]      eof_frm_bytes,
   output logic                             eof_last,
   output logic                             first_payload
);
   import tlv_pkg::*;

   localparam int bv_w = $clog2(`FHP_STRB_W);
   localparam logic [`FHP_FRM_BYTES_W-1:0] word_bytes = `FHP_FRM_BYTES_W'(`FHP_STRB_W);

   logic                          hdr_beat;
   logic                          payload_beat;
   logic                          first_pend;
   logic                          last_cmd;
   logic [bv_w-1:0]               bytes_now;
   logic [`FHP_FRM_BYTES_W-1:0]   tail_bytes;
   logic [`FHP_FRM_BYTES_W-1:0]   frm_bytes;

   // Low ones of the strobe, full strobe wraps to 0
   function automatic logic [bv_w-1:0] strb_bytes(input logic [`FHP_STRB_W-1:0] strb);
      logic [bv_w-1:0] n;
      logic            run;
      n   = '0;
      run = 1'b1;
      for (int i = 0; i < `FHP_STRB_W; i++) begin
         if (run && strb[i]) begin
            n = n + 1'b1;
         end else begin
            run = 1'b0;
         end
      end
      return n;
   endfunction

   assign hdr_beat      = beat_valid && (state == ST_DATA) && beat_sot;
   assign payload_beat  = beat_valid && (state == ST_DATA) && !beat_sot;
   assign first_payload = payload_beat && first_pend;
   assign bytes_now     = strb_bytes(beat_strb);

   always_comb begin
      tail_bytes = '0;
      tail_bytes[bv_w-1:0] = bytes_now;
      if (bytes_now == '0) begin
         tail_bytes = word_bytes;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_valid       <= 1'b0;
         dp_sof         <= 1'b0;
         dp_eof         <= 1'b0;
         dp_bytes_valid <= '0;
         eof_frm_bytes  <= '0;
         eof_last       <= 1'b0;
         first_pend     <= 1'b0;
         last_cmd       <= 1'b0;
         frm_bytes      <= '0;
      end else begin
         dp_valid       <= payload_beat;
         dp_sof         <= first_payload;
         dp_eof         <= payload_beat && beat_eot;
         dp_bytes_valid <= payload_beat ? bytes_now : '0;
         eof_frm_bytes  <= '0;
         eof_last       <= 1'b0;

         if (hdr_beat) begin
            last_cmd   <= beat_data[`FHP_LOC_BIT];
            first_pend <= 1'b1;
            frm_bytes  <= '0;
         end else if (payload_beat) begin
            first_pend <= 1'b0;
            if (beat_eot) begin
               eof_frm_bytes <= frm_bytes + tail_bytes;
               eof_last      <= last_cmd;
               frm_bytes     <= '0;
            end else begin
               frm_bytes <= frm_bytes + word_bytes;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (payload_beat) begin
         dp_data <= beat_data;
      end
   end

endmodule

//--- src/sof_detector.sv
//////////////////////////////////////////////////
// Start-of-frame detector
// Classifies the frame format, issues descriptor
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fhp_config.svh"

module sof_detector (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        first_payload,
   input  logic [`FHP_DATA_W-1:0]      dp_data,
   input  logic                        pfx_present,
   input  logic [`FHP_PFX_LEN_W-1:0]   pfx_words,
   input  logic                        pfx_crc_err,
   output logic                        sof_valid,
   output fhp_pkg::frame_fmt_e         sof_fmt,
   output fhp_pkg::fhp_error_e         sof_error,
   output logic [`FHP_PFX_LEN_W-1:0]   sof_pfx_words
);
   import fhp_pkg::*;

   frame_fmt_e fmt;
   fhp_error_e err;
   logic       pfx_window;

   assign pfx_window = |dp_data[`FHP_XP10_PFX_MSB:`FHP_XP10_PFX_LSB];

   always_comb begin
      if (dp_data[31:0] == `FHP_XP9_ID) begin
         fmt = XP9;
      end else if (dp_data[31:0] == `FHP_XP10_ID) begin
         fmt = XP10;
      end else if ((dp_data[7:0] == `FHP_GZIP_ID1) && (dp_data[15:8] == `FHP_GZIP_ID2)) begin
         fmt = GZIP;
      end else if (dp_data[3:0] == `FHP_ZLIB_CM) begin
         fmt = ZLIB;
      end else begin
         fmt = NONE;
      end

      // Format problems outrank a pending CRC error
      if (fmt == NONE) begin
         err = BAD_FORMAT;
      end else if (pfx_crc_err) begin
         err = PFX_CRC;
      end else if ((fmt == XP10) && !pfx_present && pfx_window) begin
         err = PFX_DATA_ABSENT;
      end else begin
         err = NO_ERRORS;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sof_valid     <= 1'b0;
         sof_fmt       <= NONE;
         sof_error     <= NO_ERRORS;
         sof_pfx_words <= '0;
      end else begin
         sof_valid <= first_payload;
         if (first_payload) begin
            sof_fmt       <= fmt;
            sof_error     <= err;
            sof_pfx_words <= pfx_present ? pfx_words : '0;
         end else begin
            sof_fmt       <= NONE;
            sof_error     <= NO_ERRORS;
            sof_pfx_words <= '0;
         end
      end
   end

endmodule

//--- src/fhp_top.sv
//////////////////////////////////////////////////
// Frame header parser top level
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fhp_config.svh"

module fhp_top (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             in_valid,
   input  logic                             in_sot,
   input  logic                             in_eot,
   input  tlv_pkg::tlv_type_e               in_type,
   input  logic [`FHP_DATA_W-1:0]           in_data,
   input  logic [`FHP_STRB_W-1:0]           in_strb,
   output logic                             pfx_valid,
   output logic [`FHP_DATA_W-1:0]           pfx_data,
   output logic                             pfx_sof,
   output logic                             pfx_last,
   output logic                             dp_valid,
   output logic [`FHP_DATA_W-1:0]           dp_data,
   output logic                             dp_sof,
   output logic                             dp_eof,
   output logic [$clog2(`FHP_STRB_W)-1:0]   dp_bytes_valid,
   output logic [`FHP_FRM_BYTES_W-1:0]      eof_frm_bytes,
   output logic                             eof_last,
   output logic                             sof_valid,
   output fhp_pkg::frame_fmt_e              sof_fmt,
   output fhp_pkg::fhp_error_e              sof_error,
   output logic [`FHP_PFX_LEN_W-1:0]        sof_pfx_words
);
   import tlv_pkg::*;

   logic                        beat_valid;
   logic                        beat_sot;
   logic                        beat_eot;
   logic [`FHP_DATA_W-1:0]      beat_data;
   logic [`FHP_STRB_W-1:0]      beat_strb;
   fhp_state_e                  state;
   logic                        pfx_present;
   logic [`FHP_PFX_LEN_W-1:0]   pfx_words;
   logic                        pfx_crc_err;
   logic                        first_payload;

   tlv_dispatch u_dispatch (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_sot     (in_sot),
      .in_eot     (in_eot),
      .in_type    (in_type),
      .in_data    (in_data),
      .in_strb    (in_strb),
      .beat_valid (beat_valid),
      .beat_sot   (beat_sot),
      .beat_eot   (beat_eot),
      .beat_data  (beat_data),
      .beat_strb  (beat_strb),
      .state      (state)
   );

   prefix_checker u_prefix (
      .clk         (clk),
      .rst_n       (rst_n),
      .beat_valid  (beat_valid),
      .beat_sot    (beat_sot),
      .beat_eot    (beat_eot),
      .beat_data   (beat_data),
      .state       (state),
      .sof_valid   (sof_valid),
      .pfx_valid   (pfx_valid),
      .pfx_data    (pfx_data),
      .pfx_sof     (pfx_sof),
      .pfx_last    (pfx_last),
      .pfx_present (pfx_present),
      .pfx_words   (pfx_words),
      .pfx_crc_err (pfx_crc_err)
   );

   data_framer u_framer (
      .clk            (clk),
      .rst_n          (rst_n),
      .beat_valid     (beat_valid),
      .beat_sot       (beat_sot),
      .beat_eot       (beat_eot),
      .beat_data      (beat_data),
      .beat_strb      (beat_strb),
      .state          (state),
      .dp_valid       (dp_valid),
      .dp_data        (dp_data),
      .dp_sof         (dp_sof),
      .dp_eof         (dp_eof),
      .dp_bytes_valid (dp_bytes_valid),
      .eof_frm_bytes  (eof_frm_bytes),
      .eof_last       (eof_last),
      .first_payload  (first_payload)
   );

   // Classified one stage ahead so the descriptor lines up with dp_sof
   sof_detector u_sof (
      .clk           (clk),
      .rst_n         (rst_n),
      .first_payload (first_payload),
      .dp_data       (beat_data),
      .pfx_present   (pfx_present),
      .pfx_words     (pfx_words),
      .pfx_crc_err   (pfx_crc_err),
      .sof_valid     (sof_valid),
      .sof_fmt       (sof_fmt),
      .sof_error     (sof_error),
      .sof_pfx_words (sof_pfx_words)
   );

endmodule

//--- test/tb_fhp.sv
//////////////////////////////////////////////////
// Frame header parser testbench
// Reference model, queued expectations, checks
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fhp_config.svh"

module tb_fhp;
   import tlv_pkg::*;
   import fhp_pkg::*;

   localparam int rand_frames   = 16;
   localparam int max_beats     = 80 + rand_frames * 20;
   localparam int watchdog_cyc  = 2000 + 20 * max_beats;

   typedef struct packed {
      logic [63:0] data;
      logic        sof;
      logic        last;
      logic [31:0] cyc;
   } pfx_exp_t;

   typedef struct packed {
      logic [63:0] data;
      logic        sof;
      logic        eof;
      logic [2:0]  bv;
      logic [27:0] frm;
      logic        last;
      logic [31:0] cyc;
   } dp_exp_t;

   typedef struct packed {
      frame_fmt_e  fmt;
      fhp_error_e  err;
      logic [7:0]  pw;
      logic [31:0] cyc;
   } sof_exp_t;

   logic                            clk;
   logic                            rst_n;
   logic                            in_valid;
   logic                            in_sot;
   logic                            in_eot;
   tlv_type_e                       in_type;
   logic [`FHP_DATA_W-1:0]          in_data;
   logic [`FHP_STRB_W-1:0]          in_strb;
   logic                            pfx_valid;
   logic [`FHP_DATA_W-1:0]          pfx_data;
   logic                            pfx_sof;
   logic                            pfx_last;
   logic                            dp_valid;
   logic [`FHP_DATA_W-1:0]          dp_data;
   logic                            dp_sof;
   logic                            dp_eof;
   logic [2:0]                      dp_bytes_valid;
   logic [`FHP_FRM_BYTES_W-1:0]     eof_frm_bytes;
   logic                            eof_last;
   logic                            sof_valid;
   frame_fmt_e                      sof_fmt;
   fhp_error_e                      sof_error;
   logic [`FHP_PFX_LEN_W-1:0]       sof_pfx_words;

   logic [31:0]                     cyc;
   pfx_exp_t                        pfx_q[$];
   dp_exp_t                         dp_q[$];
   sof_exp_t                        sof_q[$];

   // Model of the prefix flags held for the next frame
   logic                            m_present;
   logic [7:0]                      m_words;
   logic                            m_crc_err;

   fhp_top dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .in_valid       (in_valid),
      .in_sot         (in_sot),
      .in_eot         (in_eot),
      .in_type        (in_type),
      .in_data        (in_data),
      .in_strb        (in_strb),
      .pfx_valid      (pfx_valid),
      .pfx_data       (pfx_data),
      .pfx_sof        (pfx_sof),
      .pfx_last       (pfx_last),
      .dp_valid       (dp_valid),
      .dp_data        (dp_data),
      .dp_sof         (dp_sof),
      .dp_eof         (dp_eof),
      .dp_bytes_valid (dp_bytes_valid),
      .eof_frm_bytes  (eof_frm_bytes),
      .eof_last       (eof_last),
      .sof_valid      (sof_valid),
      .sof_fmt        (sof_fmt),
      .sof_error      (sof_error),
      .sof_pfx_words  (sof_pfx_words)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   ////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////

   // Reflected CRC-32, byte 0 of the word first
   function automatic logic [31:0] crc_add_word(input logic [31:0] crc, input logic [63:0] w);
      logic [31:0] c;
      c = crc;
      for (int b = 0; b < 8; b++) begin
         c = c ^ {24'h0, w[8*b +: 8]};
         for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
         end
      end
      return c;
   endfunction

   function automatic int low_ones(input logic [7:0] s);
      int n;
      n = 0;
      for (int i = 0; i < 8; i++) begin
         if (s[i] && n == i) begin
            n = i + 1;
         end
      end
      return n;
   endfunction

   function automatic logic [7:0] mask_of(input int k);
      return 8'((9'h1 << k) - 9'h1);
   endfunction

   function automatic frame_fmt_e ref_format(input logic [63:0] w);
      if (w[31:0] == `FHP_XP9_ID) return XP9;
      if (w[31:0] == `FHP_XP10_ID) return XP10;
      if (w[7:0] == `FHP_GZIP_ID1 && w[15:8] == `FHP_GZIP_ID2) return GZIP;
      if (w[3:0] == `FHP_ZLIB_CM) return ZLIB;
      return NONE;
   endfunction

   function automatic fhp_error_e ref_error(input frame_fmt_e f, input logic [63:0] w);
      if (f == NONE) return BAD_FORMAT;
      if (m_crc_err) return PFX_CRC;
      if (f == XP10 && !m_present && (|w[`FHP_XP10_PFX_MSB:`FHP_XP10_PFX_LSB]))
         return PFX_DATA_ABSENT;
      return NO_ERRORS;
   endfunction

   // First payload word of a given format, 0 XP9 up to 4 unknown
   function automatic logic [63:0] first_word(input int kind, input logic window);
      logic [63:0] w;
      w = {$urandom, $urandom};
      case (kind)
         0: w[31:0] = `FHP_XP9_ID;
         1: begin
            w[31:0] = `FHP_XP10_ID;
            w[`FHP_XP10_PFX_MSB:`FHP_XP10_PFX_LSB] = window ? 8'(1 + $urandom_range(0, 254)) : 8'h00;
         end
         2: w[15:0] = {`FHP_GZIP_ID2, `FHP_GZIP_ID1};
         3: w[7:0] = 8'h78;
         default: w[7:0] = 8'h00;
      endcase
      return w;
   endfunction

   ////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////

   task automatic drive_beat(input logic sot, input logic eot, input tlv_type_e t,
                             input logic [63:0] d, input logic [7:0] s);
      @(posedge clk);
      #1;
      in_valid = 1'b1;
      in_sot   = sot;
      in_eot   = eot;
      in_type  = t;
      in_data  = d;
      in_strb  = s;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         in_valid = 1'b0;
         in_sot   = 1'b0;
         in_eot   = 1'b0;
      end
   endtask

   task automatic send_prefix(input int n, input logic bad);
      logic [63:0] hdr;
      logic [63:0] w;
      logic [31:0] crc;
      pfx_exp_t    pe;
      crc = 32'hFFFFFFFF;
      hdr = {$urandom, $urandom};
      hdr[`FHP_PFX_LEN_W-1:0] = 8'(n);
      drive_beat(1'b1, 1'b0, PFD, hdr, 8'hff);
      m_present = 1'b1;
      m_words   = 8'(n);
      for (int i = 0; i < n; i++) begin
         w = {$urandom, $urandom};
         drive_beat(1'b0, 1'b0, PFD, w, 8'hff);
         pe.data = w;
         pe.sof  = (i == 0);
         pe.last = (i == n - 1);
         pe.cyc  = cyc + 2;
         pfx_q.push_back(pe);
         crc = crc_add_word(crc, w);
      end
      crc = ~crc;
      if (bad) begin
         crc = crc ^ (32'h1 << $urandom_range(0, 31));
      end
      drive_beat(1'b0, 1'b1, PFD, {$urandom, crc}, 8'hff);
      m_crc_err = bad;
      idle_cycles(2 + $urandom_range(0, 2));
   endtask

   task automatic send_data(input int npay, input logic [63:0] fw, input int last_k,
                            input logic loc, input logic unk);
      logic [63:0] hdr;
      logic [63:0] w;
      logic [7:0]  s;
      int          n;
      tlv_type_e   t;
      frame_fmt_e  f;
      dp_exp_t     de;
      sof_exp_t    se;
      t = unk ? DATA_UNK : DATA;
      hdr = {$urandom, $urandom};
      hdr[`FHP_LOC_BIT] = loc;
      drive_beat(1'b1, 1'b0, t, hdr, 8'hff);
      for (int i = 0; i < npay; i++) begin
         w = (i == 0) ? fw : {$urandom, $urandom};
         s = (i == npay - 1) ? mask_of(last_k) : 8'hff;
         drive_beat(1'b0, i == npay - 1, t, w, s);
         n = low_ones(s);
         de.data = w;
         de.sof  = (i == 0);
         de.eof  = (i == npay - 1);
         de.bv   = 3'(n);
         de.frm  = de.eof ? 28'(8 * (npay - 1) + n) : 28'h0;
         de.last = de.eof ? loc : 1'b0;
         de.cyc  = cyc + 2;
         dp_q.push_back(de);
         if (i == 0) begin
            f = ref_format(w);
            se.fmt = f;
            se.err = ref_error(f, w);
            se.pw  = m_present ? m_words : 8'h00;
            se.cyc = cyc + 2;
            sof_q.push_back(se);
            m_present = 1'b0;
            m_words   = 8'h00;
            m_crc_err = 1'b0;
         end
      end
      idle_cycles(2 + $urandom_range(0, 2));
   endtask

   // TLV types that the parser must swallow
   task automatic send_skip(input tlv_type_e t, input int nbeats);
      for (int i = 0; i < nbeats; i++) begin
         drive_beat(i == 0, i == nbeats - 1, t, {$urandom, $urandom}, 8'hff);
      end
      idle_cycles(2 + $urandom_range(0, 2));
   endtask

   ////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////

   task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "output mismatch");
   endtask

   task automatic check_prefix();
      logic     exp_v;
      pfx_exp_t e;
      exp_v = (pfx_q.size() != 0) && (pfx_q[0].cyc == cyc);
      assert (pfx_valid == exp_v) else report_value("pfx_valid", 64'(exp_v), 64'(pfx_valid));
      if (exp_v) begin
         e = pfx_q.pop_front();
         assert (pfx_data == e.data) else report_value("pfx_data", e.data, pfx_data);
         assert (pfx_sof == e.sof) else report_value("pfx_sof", 64'(e.sof), 64'(pfx_sof));
         assert (pfx_last == e.last) else report_value("pfx_last", 64'(e.last), 64'(pfx_last));
      end
   endtask

   task automatic check_data();
      logic    exp_v;
      dp_exp_t e;
      exp_v = (dp_q.size() != 0) && (dp_q[0].cyc == cyc);
      assert (dp_valid == exp_v) else report_value("dp_valid", 64'(exp_v), 64'(dp_valid));
      if (exp_v) begin
         e = dp_q.pop_front();
         assert (dp_data == e.data) else report_value("dp_data", e.data, dp_data);
         assert (dp_sof == e.sof) else report_value("dp_sof", 64'(e.sof), 64'(dp_sof));
         assert (dp_eof == e.eof) else report_value("dp_eof", 64'(e.eof), 64'(dp_eof));
         assert (dp_bytes_valid == e.bv)
            else report_value("dp_bytes_valid", 64'(e.bv), 64'(dp_bytes_valid));
         assert (eof_frm_bytes == e.frm)
            else report_value("eof_frm_bytes", 64'(e.frm), 64'(eof_frm_bytes));
         assert (eof_last == e.last) else report_value("eof_last", 64'(e.last), 64'(eof_last));
      end
   endtask

   task automatic check_sof();
      logic     exp_v;
      sof_exp_t e;
      exp_v = (sof_q.size() != 0) && (sof_q[0].cyc == cyc);
      assert (sof_valid == exp_v) else report_value("sof_valid", 64'(exp_v), 64'(sof_valid));
      assert (sof_valid == dp_sof) else report_value("sof_valid", 64'(dp_sof), 64'(sof_valid));
      if (exp_v) begin
         e = sof_q.pop_front();
         assert (sof_fmt == e.fmt) else report_value("sof_fmt", 64'(e.fmt), 64'(sof_fmt));
         assert (sof_error == e.err) else report_value("sof_error", 64'(e.err), 64'(sof_error));
         assert (sof_pfx_words == e.pw)
            else report_value("sof_pfx_words", 64'(e.pw), 64'(sof_pfx_words));
      end
   endtask

   // Outputs settle after the rising edge, so look at the falling one
   always @(negedge clk) begin
      if (rst_n) begin
         check_prefix();
         check_data();
         check_sof();
      end
   end

   initial begin
      repeat (watchdog_cyc) @(posedge clk);
      $display("Watchdog expired before the tests finished");
      $display("Simulation failed");
      $fatal(1, "timeout");
   end

   ////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////

   initial begin
      void'($urandom(67312));
      clk       = 1'b0;
      rst_n     = 1'b0;
      cyc       = 32'd0;
      in_valid  = 1'b0;
      in_sot    = 1'b0;
      in_eot    = 1'b0;
      in_type   = CMD;
      in_data   = '0;
      in_strb   = '0;
      m_present = 1'b0;
      m_words   = 8'h00;
      m_crc_err = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      idle_cycles(3);

      // Good prefix, then XP10 that asks for one
      send_prefix(3, 1'b0);
      send_data(4, first_word(1, 1'b1), 5, 1'b1, 1'b0);
      // Corrupted trailer, CMD in between, then a clean frame
      send_prefix(2, 1'b1);
      send_skip(CMD, 2);
      send_data(2, first_word(0, 1'b0), 8, 1'b0, 1'b1);
      send_data(1, first_word(2, 1'b0), 3, 1'b1, 1'b0);
      // XP10 without a prefix
      send_data(3, first_word(1, 1'b1), 1, 1'b0, 1'b0);
      send_data(2, first_word(1, 1'b0), 7, 1'b0, 1'b0);
      // Unknown format wins over a pending CRC error
      send_prefix(1, 1'b1);
      send_data(2, first_word(4, 1'b0), 4, 1'b1, 1'b0);
      send_data(3, first_word(3, 1'b0), 2, 1'b0, 1'b1);
      send_skip(tlv_type_e'(5'h09), 3);
      send_skip(tlv_type_e'(5'h1f), 1);

      for (int i = 0; i < rand_frames; i++) begin
         if ($urandom_range(0, 2) == 0) begin
            send_prefix($urandom_range(1, 6), $urandom_range(0, 3) == 0);
         end
         if ($urandom_range(0, 1) == 0) begin
            send_skip(($urandom_range(0, 1) == 0) ? CMD : tlv_type_e'(5'h0b),
                      $urandom_range(1, 3));
         end
         send_data($urandom_range(1, 8),
                   first_word($urandom_range(0, 4), $urandom_range(0, 1) == 1),
                   $urandom_range(1, 8), $urandom_range(0, 1) == 1,
                   $urandom_range(0, 1) == 1);
      end

      idle_cycles(8);
      if (pfx_q.size() == 0 && dp_q.size() == 0 && sof_q.size() == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("Expected outputs never appeared");
         $display("Simulation failed");
         $fatal(1, "pending expectations");
      end
   end

endmodule

//--- compile.f
+incdir+src
src/tlv_pkg.sv
src/fhp_pkg.sv
src/crc32_64.sv
src/tlv_dispatch.sv
src/prefix_checker.sv
src/data_framer.sv
src/sof_detector.sv
src/fhp_top.sv
test/tb_fhp.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_fhp
FILELIST  = compile.f
BUILD_DIR = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
